/* dcache.f */
+incdir+src
src/dcache_pkg.sv
src/dcache_way.sv
src/dcache_replace.sv
src/dcache_ctrl.sv
src/dcache.sv
testbench/dcache_chk.sv
testbench/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the dcache testbench with verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dcache_tb -f dcache.f -o dcache_sim \
    || { echo "build failed"; exit 1; }

result=$(./obj_dir/dcache_sim +verilator+error+limit+100)
echo "$result"
echo "$result" | grep -qxF "All tests passed!" && echo "PASS" || { echo "FAIL"; exit 1; }

/* src/dcache.sv */
`include "dcache_consts.svh"

module dcache (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              dmemREN,
    input  logic              dmemWEN,
    input  logic              halt,
    input  dcache_pkg::word_t dmemaddr,
    input  dcache_pkg::word_t dmemstore,
    input  dcache_pkg::word_t dload,
    input  logic              dwait,
    output logic              dhit,
    output logic              flushed,
    output logic              dREN,
    output logic              dWEN,
    output dcache_pkg::word_t dmemload,
    output dcache_pkg::word_t daddr,
    output dcache_pkg::word_t dstore
);

    dcache_pkg::dcache_addr_u req_addr;
    logic [`DC_IDX_W-1:0] set_idx;
    logic [`DC_WAYS-1:0] store_en, fill_en, way_hit;
    logic fill_blk;
    dcache_pkg::word_t fill_data, store_data;
    logic touch, touch_way, view_way;
    logic any_hit, victim_way, view_dirty;
    dcache_pkg::word_t hit_word, view_data0, view_data1;
    logic [`DC_TAG_W-1:0] view_tag;

    // per-way frame views
    logic [`DC_TAG_W-1:0] tag_w [`DC_WAYS];
    logic dirty_w [`DC_WAYS];
    dcache_pkg::word_t data0_w [`DC_WAYS];
    dcache_pkg::word_t data1_w [`DC_WAYS];

    assign req_addr.word = dmemaddr;

    dcache_ctrl u_ctrl (.*);

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        dcache_way u_way (
            .CLK         (CLK),
            .nRST        (nRST),
            .req_addr    (req_addr),
            .set_idx     (set_idx),
            .store_en    (store_en[w]),
            .store_data  (store_data),
            .fill_en     (fill_en[w]),
            .fill_blk    (fill_blk),
            .fill_data   (fill_data),
            .hit         (way_hit[w]),
            .frame_tag   (tag_w[w]),
            .frame_valid (),    // dirty implies valid here
            .frame_dirty (dirty_w[w]),
            .frame_data0 (data0_w[w]),
            .frame_data1 (data1_w[w])
        );
    end

    dcache_replace u_replace (
        .blkoff (req_addr.f.blkoff),
        .*
    );

endmodule

/* src/dcache_consts.svh */
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry
`define DC_SETS 8
`define DC_WAYS 2 // one lru bit per set covers two ways

// address split, msb first
`define DC_TAG_W 26
`define DC_IDX_W 3
`define DC_BLK_W 1
`define DC_BYT_W 2

// bytes in one memory word
`define DC_WORD_BYTES 4

// frames visited by the halt flush walk, sets times ways
`define DC_FRAMES 16

`endif

/* src/dcache_ctrl.sv */
`include "dcache_consts.svh"

module dcache_ctrl (
    input  logic                 CLK,
    input  logic                 nRST,
    // datapath side
    input  logic                 dmemREN,
    input  logic                 dmemWEN,
    input  logic                 halt,
    input  dcache_pkg::word_t    dmemaddr,
    input  dcache_pkg::word_t    dmemstore,
    output logic                 dhit,
    output logic                 flushed,
    output dcache_pkg::word_t    dmemload,
    // memory side
    input  dcache_pkg::word_t    dload,
    input  logic                 dwait,
    output logic                 dREN,
    output logic                 dWEN,
    output dcache_pkg::word_t    daddr,
    output dcache_pkg::word_t    dstore,
    // way control
    output logic [`DC_IDX_W-1:0] set_idx,
    output logic [`DC_WAYS-1:0]  store_en,
    output logic [`DC_WAYS-1:0]  fill_en,
    output logic                 fill_blk,
    output dcache_pkg::word_t    fill_data,
    output dcache_pkg::word_t    store_data,
    input  logic [`DC_WAYS-1:0]  way_hit,
    // replacement selector
    output logic                 touch,
    output logic                 touch_way,
    output logic                 view_way,
    input  logic                 any_hit,
    input  dcache_pkg::word_t    hit_word,
    input  logic                 victim_way,
    input  logic [`DC_TAG_W-1:0] view_tag,
    input  logic                 view_dirty,
    input  dcache_pkg::word_t    view_data0,
    input  dcache_pkg::word_t    view_data1
);

    dcache_pkg::dc_state_t state, n_state;
    logic [4:0] frame_cnt, n_frame_cnt; // flush walk position, 0 to 16
    dcache_pkg::dcache_addr_u req;
    dcache_pkg::dcache_addr_u mem_addr;
    logic flushing;
    logic second;   // second word of a block transfer
    logic is_load;
    logic mem_done;

    assign req.word = dmemaddr;
    assign mem_done = !dwait;

    assign flushing = state inside {dcache_pkg::DIRTY, dcache_pkg::FLUSH1, dcache_pkg::FLUSH2};
    assign second   = state inside {dcache_pkg::WB2, dcache_pkg::LD2, dcache_pkg::FLUSH2};
    assign is_load  = state inside {dcache_pkg::LD1, dcache_pkg::LD2};

    // walk covers way 0 sets first, then way 1
    assign set_idx  = flushing ? frame_cnt[`DC_IDX_W-1:0] : req.f.idx;
    assign view_way = flushing ? frame_cnt[`DC_IDX_W] : victim_way;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= dcache_pkg::IDLE;
            frame_cnt <= '0;
        end else begin
            state     <= n_state;
            frame_cnt <= n_frame_cnt;
        end
    end

    always_comb begin
        n_state     = state;
        n_frame_cnt = frame_cnt;
        case (state)
            dcache_pkg::IDLE: begin
                if (halt) begin
                    n_state = dcache_pkg::DIRTY;
                end else if ((dmemREN || dmemWEN) && !any_hit) begin
                    // victim dirty bit decides if write-back comes first
                    n_state = view_dirty ? dcache_pkg::WB1 : dcache_pkg::LD1;
                end
            end
            dcache_pkg::WB1: if (mem_done) n_state = dcache_pkg::WB2;
            dcache_pkg::WB2: if (mem_done) n_state = dcache_pkg::LD1;
            dcache_pkg::LD1: if (mem_done) n_state = dcache_pkg::LD2;
            dcache_pkg::LD2: if (mem_done) n_state = dcache_pkg::IDLE; // held request hits next
            dcache_pkg::DIRTY: begin
                if (frame_cnt == 5'(`DC_FRAMES)) begin
                    n_state = dcache_pkg::HALT;
                end else if (view_dirty) begin
                    n_state = dcache_pkg::FLUSH1;
                end else begin
                    n_frame_cnt = frame_cnt + 5'd1; // clean frame, skip
                end
            end
            dcache_pkg::FLUSH1: if (mem_done) n_state = dcache_pkg::FLUSH2;
            dcache_pkg::FLUSH2: begin
                if (mem_done) begin
                    n_state     = dcache_pkg::DIRTY;
                    n_frame_cnt = frame_cnt + 5'd1;
                end
            end
            dcache_pkg::HALT: n_state = dcache_pkg::HALT;
            default: n_state = dcache_pkg::IDLE;
        endcase
    end

    // memory strobes and address, held steady while dwait is high
    always_comb begin
        dREN = is_load;
        dWEN = state inside {dcache_pkg::WB1, dcache_pkg::WB2,
                             dcache_pkg::FLUSH1, dcache_pkg::FLUSH2};
        mem_addr.f.tag    = is_load ? req.f.tag : view_tag;
        mem_addr.f.idx    = set_idx;
        mem_addr.f.blkoff = second;
        mem_addr.f.bytoff = '0;
        daddr  = mem_addr.word;
        dstore = second ? view_data1 : view_data0;
    end

    // hit answer, stores, fills and lru touches
    always_comb begin
        dhit      = 1'b0;
        touch     = 1'b0;
        touch_way = way_hit[1];
        store_en  = '0;
        fill_en   = '0;
        case (state)
            dcache_pkg::IDLE: begin
                if (!halt && (dmemREN || dmemWEN) && any_hit) begin
                    dhit  = 1'b1;
                    touch = 1'b1;
                    if (dmemWEN) begin
                        store_en = way_hit; // store into the matching way
                    end
                end
            end
            dcache_pkg::LD1: begin
                if (mem_done) fill_en[victim_way] = 1'b1;
            end
            dcache_pkg::LD2: begin
                if (mem_done) begin
                    fill_en[victim_way] = 1'b1;
                    touch     = 1'b1;
                    touch_way = victim_way;
                end
            end
            default: ;
        endcase
    end

    assign fill_blk   = second;
    assign fill_data  = dload;
    assign store_data = dmemstore;
    assign dmemload   = hit_word;
    assign flushed    = (state == dcache_pkg::HALT);

endmodule

/* src/dcache_pkg.sv */
`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [8*`DC_WORD_BYTES-1:0] word_t; // data or address word

    // address word, used whole or split into cache fields
    typedef union packed {
        word_t word;
        struct packed {
            logic [`DC_TAG_W-1:0] tag;
            logic [`DC_IDX_W-1:0] idx;
            logic [`DC_BLK_W-1:0] blkoff;
            logic [`DC_BYT_W-1:0] bytoff;
        } f;
    } dcache_addr_u;

    typedef enum logic [3:0] {
        IDLE,   // hits answered here
        WB1,    // victim write-back, word 0
        WB2,    // victim write-back, word 1
        LD1,    // block fetch, word 0
        LD2,    // block fetch, word 1
        DIRTY,  // flush walk, checks one frame
        FLUSH1,
        FLUSH2,
        HALT    // flushed, stays here until reset
    } dc_state_t;

endpackage

/* src/dcache_replace.sv */
`include "dcache_consts.svh"

module dcache_replace (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic [`DC_IDX_W-1:0] set_idx,
    input  logic                 blkoff,
    input  logic [`DC_WAYS-1:0]  way_hit,
    input  dcache_pkg::word_t    data0_w [`DC_WAYS],
    input  dcache_pkg::word_t    data1_w [`DC_WAYS],
    input  logic [`DC_TAG_W-1:0] tag_w [`DC_WAYS],
    input  logic                 dirty_w [`DC_WAYS],
    input  logic                 touch,
    input  logic                 touch_way,
    input  logic                 view_way,
    output logic                 any_hit,
    output dcache_pkg::word_t    hit_word,
    output logic                 victim_way,
    output logic [`DC_TAG_W-1:0] view_tag,
    output logic                 view_dirty,
    output dcache_pkg::word_t    view_data0,
    output dcache_pkg::word_t    view_data1
);

    logic [`DC_SETS-1:0] lru_q; // per set, the way to evict next
    logic hit_sel;
    dcache_pkg::word_t hit_data0;
    dcache_pkg::word_t hit_data1;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lru_q <= '0;
        end else if (touch) begin
            lru_q[set_idx] <= ~touch_way; // the other way ages
        end
    end

    assign victim_way = lru_q[set_idx];

    // hit mux
    // at most one way matches, so way 1's hit bit picks the way
    assign any_hit   = |way_hit;
    assign hit_sel   = way_hit[1];
    assign hit_data0 = data0_w[hit_sel];
    assign hit_data1 = data1_w[hit_sel];
    assign hit_word  = blkoff ? hit_data1 : hit_data0;

    // frame for write-back, victim or flush frame
    assign view_tag   = tag_w[view_way];
    assign view_dirty = dirty_w[view_way];
    assign view_data0 = data0_w[view_way];
    assign view_data1 = data1_w[view_way];

endmodule

/* src/dcache_way.sv */
`include "dcache_consts.svh"

module dcache_way (
    input  logic                     CLK,
    input  logic                     nRST,
    input  dcache_pkg::dcache_addr_u req_addr,
    input  logic [`DC_IDX_W-1:0]     set_idx,
    input  logic                     store_en,
    input  dcache_pkg::word_t        store_data,
    input  logic                     fill_en,
    input  logic                     fill_blk,
    input  dcache_pkg::word_t        fill_data,
    output logic                     hit,
    output logic [`DC_TAG_W-1:0]     frame_tag,
    output logic                     frame_valid,
    output logic                     frame_dirty,
    output dcache_pkg::word_t        frame_data0,
    output dcache_pkg::word_t        frame_data1
);

    logic [`DC_SETS-1:0] valid_q;
    logic [`DC_SETS-1:0] dirty_q;
    logic [`DC_TAG_W-1:0] tag_q [`DC_SETS];
    dcache_pkg::word_t data_q [`DC_SETS][2]; // two words per block

    // frame status bits
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (store_en) begin
            dirty_q[set_idx] <= 1'b1;
        end else if (fill_en) begin
            if (!fill_blk) begin
                valid_q[set_idx] <= 1'b1; // new tag lands with word 0
            end else begin
                dirty_q[set_idx] <= 1'b0; // block now matches memory
            end
        end
    end

    // tag and block words
    always_ff @(posedge CLK) begin
        if (store_en) begin
            data_q[set_idx][req_addr.f.blkoff] <= store_data;
        end
        if (fill_en) begin
            data_q[set_idx][fill_blk] <= fill_data;
            if (!fill_blk) begin
                tag_q[set_idx] <= req_addr.f.tag;
            end
        end
    end

    // lookup always at the request's own index
    assign hit = valid_q[req_addr.f.idx] && (tag_q[req_addr.f.idx] == req_addr.f.tag);

    // frame chosen by the controller, request or flush walk
    assign frame_tag   = tag_q[set_idx];
    assign frame_valid = valid_q[set_idx];
    assign frame_dirty = dirty_q[set_idx];
    assign frame_data0 = data_q[set_idx][0];
    assign frame_data1 = data_q[set_idx][1];

endmodule

/* testbench/dcache_chk.sv */
module dcache_chk (
    input logic              CLK,
    input logic              nRST,
    input logic              dREN,
    input logic              dWEN,
    input logic              dhit,
    input logic              flushed,
    input dcache_pkg::word_t daddr
);

    int fail_count = 0; // failed assertion count

    a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
        else begin
            $error("dREN and dWEN high in the same cycle");
            fail_count++;
        end

    // memory moves whole words only
    a_word_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        (dREN || dWEN) |-> (daddr[1:0] == 2'b00))
        else begin
            $error("daddr 0x%h not word aligned", daddr);
            fail_count++;
        end

    a_flushed_holds: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
        else begin
            $error("flushed dropped before reset");
            fail_count++;
        end

    a_no_hit_on_bus: assert property (@(posedge CLK) disable iff (!nRST)
        !(dhit && (dREN || dWEN)))
        else begin
            $error("dhit raised during a memory transfer");
            fail_count++;
        end

endmodule

/* testbench/dcache_tb.sv */
`include "dcache_consts.svh"

module dcache_tb;

    localparam int MEM_WORDS   = 64;
    localparam int HIT_LIMIT   = 64;              // cycles per access, worst miss is far less
    localparam int FLUSH_LIMIT = `DC_FRAMES * 64;

    localparam logic [1:0] OP_READ   = 2'd0;
    localparam logic [1:0] OP_WRITE  = 2'd1;
    localparam logic [1:0] OP_HALT   = 2'd2;
    localparam logic [1:0] OP_MEMCHK = 2'd3;   // compare one memory word with the shadow

    typedef struct packed {
        logic [1:0]        kind;
        dcache_pkg::word_t addr;
        dcache_pkg::word_t data;
        dcache_pkg::word_t exp;
        logic              quiet;              // must hit, no bus traffic
    } op_t;

    logic CLK = 1'b0;
    logic nRST;
    logic dmemREN, dmemWEN, halt;
    dcache_pkg::word_t dmemaddr, dmemstore;
    dcache_pkg::word_t dload = '0;
    logic dwait = 1'b1;
    logic dhit, flushed, dREN, dWEN;
    dcache_pkg::word_t dmemload, daddr, dstore;

    dcache_pkg::word_t mem [MEM_WORDS];
    dcache_pkg::word_t shadow [MEM_WORDS];
    op_t ops [$];
    integer seed;
    logic busy = 1'b0;
    logic [1:0] delay_left = '0;
    int ren_cycles = 0;
    int wen_cycles = 0;
    int checks = 0;
    int value_errs = 0;
    int other_errs = 0;
    bit timed_out = 1'b0;

    dcache dut (.*);

    bind dcache dcache_chk u_chk (
        .CLK     (CLK),
        .nRST    (nRST),
        .dREN    (dREN),
        .dWEN    (dWEN),
        .dhit    (dhit),
        .flushed (flushed),
        .daddr   (daddr)
    );

    always #10 CLK = ~CLK;

    function automatic dcache_pkg::word_t mem_pattern(input int idx);
        return 32'h6a5c_0000 ^ (32'(idx) * 32'h0001_0101);
    endfunction

    function automatic logic [5:0] word_index(input dcache_pkg::word_t addr);
        return addr[7:2];
    endfunction

    // memory model, one word per request with a random stall
    always @(posedge CLK) begin
        if (!nRST) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[6'(i)] <= mem_pattern(i);
            end
            dwait <= 1'b1;
            busy  <= 1'b0;
        end else if (busy && !dwait) begin
            if (dWEN) begin
                mem[word_index(daddr)] <= dstore; // word completes this edge
            end
            dwait <= 1'b1;
            busy  <= 1'b0;
        end else if (dREN || dWEN) begin
            if (!busy) begin
                delay_left <= 2'($random(seed));
                busy       <= 1'b1;
            end else if (delay_left == 2'd0) begin
                dwait <= 1'b0;
                dload <= mem[word_index(daddr)];
            end else begin
                delay_left <= delay_left - 2'd1;
            end
        end
    end

    // bus activity counters
    always @(negedge CLK) begin
        if (dREN) ren_cycles <= ren_cycles + 1;
        if (dWEN) wen_cycles <= wen_cycles + 1;
    end

    task automatic check_value(input string name, input dcache_pkg::word_t got,
                               input dcache_pkg::word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic add_op(input logic [1:0] kind, input dcache_pkg::word_t addr,
                          input dcache_pkg::word_t data, input logic quiet);
        op_t op;
        op.kind  = kind;
        op.addr  = addr;
        op.data  = data;
        op.quiet = quiet;
        if (kind == OP_WRITE) begin
            shadow[word_index(addr)] = data;
        end
        op.exp = shadow[word_index(addr)];
        ops.push_back(op);
    endtask

    task automatic build_table();
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[6'(i)] = mem_pattern(i);
        end
        add_op(OP_READ, 32'h00, '0, 1'b0);             // cold miss in set 0
        add_op(OP_READ, 32'h04, '0, 1'b1);             // other word, same block
        add_op(OP_WRITE, 32'h04, 32'h1111_2222, 1'b1); // write hit
        add_op(OP_READ, 32'h04, '0, 1'b1);
        add_op(OP_READ, 32'h40, '0, 1'b0);             // B
        add_op(OP_READ, 32'h00, '0, 1'b1);             // A again, B now least recent
        add_op(OP_READ, 32'h80, '0, 1'b0);             // C replaces B
        add_op(OP_READ, 32'h04, '0, 1'b1);
        add_op(OP_READ, 32'h84, '0, 1'b1);
        add_op(OP_WRITE, 32'h08, 32'hdead_beef, 1'b0); // write miss allocates
        add_op(OP_WRITE, 32'h0c, 32'hcafe_f00d, 1'b1);
        add_op(OP_READ, 32'h48, '0, 1'b0);
        add_op(OP_READ, 32'h88, '0, 1'b0);             // dirty block goes back
        add_op(OP_MEMCHK, 32'h08, '0, 1'b0);
        add_op(OP_MEMCHK, 32'h0c, '0, 1'b0);
        add_op(OP_READ, 32'h0c, '0, 1'b0);
        add_op(OP_WRITE, 32'h14, 32'h0bad_1dea, 1'b0);
        add_op(OP_WRITE, 32'hd8, 32'h5eed_7800, 1'b0); // both ways of set 3 dirty
        add_op(OP_WRITE, 32'h98, 32'h0f0f_a5a5, 1'b0);
        add_op(OP_READ, 32'h98, '0, 1'b1);
        add_op(OP_HALT, '0, '0, 1'b0);
    endtask

    task automatic run_access(input op_t op);
        int cycles;
        int ren_start;
        int wen_start;
        bit done;
        dcache_pkg::word_t got;
        cycles = 0;
        done   = 1'b0;
        got    = '0;
        @(posedge CLK);
        ren_start = ren_cycles;
        wen_start = wen_cycles;
        dmemREN   <= (op.kind == OP_READ);
        dmemWEN   <= (op.kind == OP_WRITE);
        dmemaddr  <= op.addr;
        dmemstore <= op.data;
        while (!done && cycles < HIT_LIMIT) begin
            @(negedge CLK);
            if (dhit) begin
                done = 1'b1;
                got  = dmemload;
            end else begin
                cycles++;
            end
        end
        @(posedge CLK);          // request retires on this edge
        dmemREN <= 1'b0;
        dmemWEN <= 1'b0;
        if (!done) begin
            $display("Error: no dhit within %0d cycles for address 0x%h", HIT_LIMIT, op.addr);
            other_errs++;
            timed_out = 1'b1;
        end else begin
            if (op.kind == OP_READ) begin
                check_value("dmemload", got, op.exp);
            end
            assert (!op.quiet || (ren_cycles == ren_start && wen_cycles == wen_start)) else begin
                $display("Error: access to 0x%h used the memory bus instead of hitting", op.addr);
                other_errs++;
            end
        end
    endtask

    task automatic run_halt();
        int cycles;
        bit done;
        cycles = 0;
        done   = 1'b0;
        @(posedge CLK);
        halt <= 1'b1;
        while (!done && cycles < FLUSH_LIMIT) begin
            @(negedge CLK);
            if (flushed) begin
                done = 1'b1;
            end else begin
                cycles++;
            end
        end
        if (!done) begin
            $display("Error: flushed did not rise within %0d cycles of halt", FLUSH_LIMIT);
            other_errs++;
            timed_out = 1'b1;
        end else begin
            repeat (8) begin
                @(negedge CLK);
                check_value("flushed", 32'(flushed), 32'h1);
            end
            for (int i = 0; i < MEM_WORDS; i++) begin
                check_value($sformatf("mem[%0d]", i), mem[6'(i)], shadow[6'(i)]);
            end
        end
    endtask

    initial begin
        nRST      = 1'b0;
        dmemREN   = 1'b0;
        dmemWEN   = 1'b0;
        halt      = 1'b0;
        dmemaddr  = '0;
        dmemstore = '0;
        seed      = 30764;
        build_table();
        repeat (4) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_value("dREN", 32'(dREN), 32'h0);
        check_value("dWEN", 32'(dWEN), 32'h0);
        check_value("dhit", 32'(dhit), 32'h0);
        check_value("flushed", 32'(flushed), 32'h0);
        for (int i = 0; i < ops.size() && !timed_out; i++) begin
            case (ops[i].kind)
                OP_READ, OP_WRITE: run_access(ops[i]);
                OP_MEMCHK: check_value($sformatf("mem[%0d]", word_index(ops[i].addr)),
                                       mem[word_index(ops[i].addr)], ops[i].exp);
                default: run_halt();
            endcase
        end
        assert (dut.u_chk.fail_count == 0) else begin
            $display("Error: bus protocol assertions failed %0d times", dut.u_chk.fail_count);
            other_errs++;
        end
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
